/* design/vdp_cartridge_pkg.sv */
/*
 * Shared constants for the VDP cartridge: I/O port map, VRAM geometry,
 * synchronizer depth and the FSM state encodings
 */
package vdp_cartridge_pkg;

	// --------------------
	// I/O port map
	// --------------------

	// VDP answers 0x98..0x9F, only bits 7:3 take part in the decode
	localparam logic [7:0] vdp_port_base = 8'h98;

	// --------------------
	// VRAM geometry
	// --------------------

	localparam int vram_aw = 14;			// byte address, 16 KB
	localparam int vram_word_aw = 12;		// 32-bit word address
	localparam int vram_words = 4096;		// words wiped after reset

	// --------------------
	// slot strobe capture
	// --------------------

	localparam int sync_stages = 2;			// flops before edge detect

	// --------------------
	// FSM encodings
	// --------------------

	typedef enum logic [1:0] {
		st_idle,							// waiting for a strobe edge
		st_request,							// transaction out, no ready yet
		st_hold								// done, strobe still low
	} slot_state_t;

	typedef enum logic [1:0] {
		ps_idle,							// free to accept a transaction
		ps_write,							// data write parked on init_busy
		ps_read,							// prefetch parked on init_busy
		ps_read_wait						// prefetch issued, awaiting rdata_en
	} port_state_t;

	typedef enum logic {
		vs_clear,							// wiping the array
		vs_ready							// normal access
	} vram_state_t;

endpackage

/* design/slot_bus.sv */
`timescale 1ns/1ps
/*
 * Z80 slot front end: strobe synchronizers, VDP port range decode,
 * one bus transaction per strobe and read data hold toward the host
 */
module slot_bus
	import vdp_cartridge_pkg::*;
(
	input	logic			clk85m,
	input	logic			rst,
	input	logic			slot_iorq_n,
	input	logic			slot_rd_n,
	input	logic			slot_wr_n,
	input	logic	[7:0]	slot_a,
	input	logic	[7:0]	slot_d,
	output	logic			busdir,
	output	logic	[7:0]	slot_d_out,
	output	logic			slot_data_dir,
	output	logic			bus_valid,
	output	logic			bus_port,
	output	logic			bus_write,
	output	logic	[7:0]	bus_wdata,
	input	logic			bus_ready,
	input	logic			bus_rdata_en,
	input	logic	[7:0]	bus_rdata
);
	logic	[sync_stages-1:0]	iorq_sync;		// shift chains, oldest at msb
	logic	[sync_stages-1:0]	rd_sync;
	logic	[sync_stages-1:0]	wr_sync;
	logic						rd_last;		// for edge detect
	logic						wr_last;
	logic						rd_fall;
	logic						wr_fall;
	logic						in_range;
	logic						strobe_hit;
	logic						strobe_idle;
	logic						data_dir_q;
	slot_state_t				state;

	// --------------------
	// decode and edges
	// --------------------

	assign in_range		= (slot_a[7:3] == vdp_port_base[7:3]);	// 0x98..0x9F
	assign busdir		= (in_range && !slot_iorq_n) ? ~slot_rd_n : 1'b0;	// raw pins

	assign rd_fall		= rd_last & ~rd_sync[sync_stages-1];
	assign wr_fall		= wr_last & ~wr_sync[sync_stages-1];
	assign strobe_hit	= (rd_fall | wr_fall) & ~iorq_sync[sync_stages-1] & in_range;
	assign strobe_idle	= rd_sync[sync_stages-1] & wr_sync[sync_stages-1];	// both released

	// never drive the data bus once the host lets go of rd_n
	assign slot_data_dir = data_dir_q & ~slot_rd_n;

	always_ff @(posedge clk85m) begin
		if (rst) begin
			iorq_sync	<= '1;
			rd_sync		<= '1;
			wr_sync		<= '1;
			rd_last		<= 1'b1;
			wr_last		<= 1'b1;
		end else begin
			iorq_sync	<= {iorq_sync[sync_stages-2:0], slot_iorq_n};
			rd_sync		<= {rd_sync[sync_stages-2:0], slot_rd_n};
			wr_sync		<= {wr_sync[sync_stages-2:0], slot_wr_n};
			rd_last		<= rd_sync[sync_stages-1];
			wr_last		<= wr_sync[sync_stages-1];
		end
	end

	// --------------------
	// transaction FSM
	// --------------------

	always_ff @(posedge clk85m) begin
		if (rst) begin
			state		<= st_idle;
			bus_valid	<= 1'b0;
			data_dir_q	<= 1'b0;
		end else begin
			bus_valid <= 1'b0;							// single-cycle pulse
			case (state)
				st_idle: begin
					if (strobe_hit) begin
						bus_valid	<= 1'b1;
						state		<= st_request;
					end
				end
				st_request: begin
					if (bus_ready) begin
						data_dir_q	<= bus_rdata_en;	// reads only
						state		<= st_hold;
					end
				end
				st_hold: begin
					if (strobe_idle) begin
						data_dir_q	<= 1'b0;
						state		<= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// address and data are stable by the time the edge gets through the chain
	always_ff @(posedge clk85m) begin
		if (state == st_idle && strobe_hit) begin
			bus_port	<= slot_a[0];					// 0 data, 1 control
			bus_write	<= wr_fall;
			bus_wdata	<= slot_d;
		end
		if (bus_rdata_en) begin
			slot_d_out	<= bus_rdata;					// held until next read
		end
	end

endmodule

/* design/vdp_port_ctrl.sv */
`timescale 1ns/1ps
/*
 * VDP port logic: two-byte address latch, auto-increment pointer,
 * read-ahead buffer and VRAM request sequencing
 */
module vdp_port_ctrl
	import vdp_cartridge_pkg::*;
(
	input	logic						clk85m,
	input	logic						rst,
	input	logic						bus_valid,
	input	logic						bus_port,
	input	logic						bus_write,
	input	logic	[7:0]				bus_wdata,
	output	logic						bus_ready,
	output	logic	[7:0]				bus_rdata,
	output	logic						bus_rdata_en,
	input	logic						init_busy,
	output	logic						vram_valid,
	output	logic						vram_write,
	output	logic	[vram_word_aw-1:0]	vram_address,
	output	logic	[31:0]				vram_wdata,
	output	logic	[3:0]				vram_wdata_mask,
	input	logic	[31:0]				vram_rdata,
	input	logic						vram_rdata_en
);
	port_state_t			state;
	logic	[vram_aw-1:0]	pointer;		// wraps at 16K
	logic	[vram_aw-1:0]	setup_addr;
	logic	[7:0]			low_byte;		// first control byte
	logic					latch_first;	// first byte already taken
	logic	[7:0]			read_buf;		// read-ahead
	logic					pend_valid;		// transaction parked during prefetch
	logic					pend_port;
	logic					pend_write;
	logic	[7:0]			pend_wdata;
	logic					take;
	logic					cur_port;
	logic					cur_write;
	logic	[7:0]			cur_wdata;
	logic					ctrl_first;
	logic					ctrl_rd;
	logic					data_wr;
	logic					data_rd;
	logic					read_setup;

	// --------------------
	// transaction decode
	// --------------------

	assign take			= (bus_valid | pend_valid) && (state == ps_idle);
	assign cur_port		= pend_valid ? pend_port : bus_port;
	assign cur_write	= pend_valid ? pend_write : bus_write;
	assign cur_wdata	= pend_valid ? pend_wdata : bus_wdata;
	assign setup_addr	= {cur_wdata[5:0], low_byte};

	assign ctrl_first	= take && cur_port && cur_write && !latch_first;
	assign ctrl_rd		= take && cur_port && !cur_write;
	assign data_wr		= take && !cur_port && cur_write;
	assign data_rd		= take && !cur_port && !cur_write;
	// second byte, bit 7 clear (address) and bit 6 clear (read mode)
	assign read_setup	= take && cur_port && cur_write && latch_first &&
						  (cur_wdata[7:6] == 2'b00);

	// --------------------
	// sequencer
	// --------------------

	always_ff @(posedge clk85m) begin
		if (rst) begin
			state		<= ps_idle;
			pointer		<= '0;
			latch_first	<= 1'b0;
			read_buf	<= '0;
			pend_valid	<= 1'b0;
			bus_ready	<= 1'b0;
			bus_rdata_en <= 1'b0;
			vram_valid	<= 1'b0;
		end else begin
			bus_ready		<= 1'b0;
			bus_rdata_en	<= 1'b0;
			vram_valid		<= 1'b0;

			if (take)
				pend_valid <= 1'b0;
			else if (bus_valid)
				pend_valid <= 1'b1;					// arrived mid-prefetch

			case (state)
				ps_idle: begin
					if (take && cur_port) begin
						bus_ready <= 1'b1;			// control port is one cycle
						if (!cur_write) begin
							latch_first		<= 1'b0;	// status read resets latch
							bus_rdata_en	<= 1'b1;
						end else if (!latch_first) begin
							latch_first		<= 1'b1;
						end else begin
							latch_first		<= 1'b0;
							if (!cur_wdata[7]) begin	// register writes just close the latch
								pointer <= setup_addr;
							end
							if (read_setup) begin
								vram_valid	<= !init_busy;
								state		<= init_busy ? ps_read : ps_read_wait;
							end
						end
					end else if (take) begin
						latch_first <= 1'b0;			// any data access
						if (cur_write) begin
							if (init_busy) begin
								state		<= ps_write;
							end else begin
								vram_valid	<= 1'b1;
								pointer		<= pointer + 1'b1;
								bus_ready	<= 1'b1;
							end
						end else begin
							bus_ready		<= 1'b1;	// buffer goes back at once
							bus_rdata_en	<= 1'b1;
							vram_valid		<= !init_busy;	// then refill it
							state			<= init_busy ? ps_read : ps_read_wait;
						end
					end
				end
				ps_write: begin
					if (!init_busy) begin
						vram_valid	<= 1'b1;
						pointer		<= pointer + 1'b1;
						bus_ready	<= 1'b1;
						state		<= ps_idle;
					end
				end
				ps_read: begin
					if (!init_busy) begin
						vram_valid	<= 1'b1;
						state		<= ps_read_wait;
					end
				end
				ps_read_wait: begin
					if (vram_rdata_en) begin
						read_buf	<= vram_rdata[pointer[1:0]*8 +: 8];	// pick lane
						pointer		<= pointer + 1'b1;
						state		<= ps_idle;
					end
				end
				default: state <= ps_idle;
			endcase
		end
	end

	// --------------------
	// payload registers
	// --------------------

	always_ff @(posedge clk85m) begin
		if (bus_valid) begin
			pend_port	<= bus_port;
			pend_write	<= bus_write;
			pend_wdata	<= bus_wdata;
		end
		if (ctrl_first)
			low_byte <= cur_wdata;
		if (ctrl_rd)
			bus_rdata <= 8'h00;						// status stub
		if (data_rd)
			bus_rdata <= read_buf;
		if (data_wr) begin
			vram_write		<= 1'b1;
			vram_address	<= pointer[vram_aw-1:2];
			vram_wdata		<= {4{cur_wdata}};		// byte on every lane
			vram_wdata_mask	<= 4'b0001 << pointer[1:0];
		end
		if (data_rd) begin
			vram_write		<= 1'b0;
			vram_address	<= pointer[vram_aw-1:2];
		end
		if (read_setup) begin
			vram_write		<= 1'b0;
			vram_address	<= setup_addr[vram_aw-1:2];
		end
	end

endmodule

/* design/vram_ctrl.sv */
`timescale 1ns/1ps
/*
 * 16 KB VRAM as 4096 x 32 with byte lane writes, post-reset wipe
 * and a two-stage read pipeline
 */
module vram_ctrl
	import vdp_cartridge_pkg::*;
(
	input	logic						clk85m,
	input	logic						rst,
	input	logic						vram_valid,
	input	logic						vram_write,
	input	logic	[vram_word_aw-1:0]	vram_address,
	input	logic	[31:0]				vram_wdata,
	input	logic	[3:0]				vram_wdata_mask,
	output	logic	[31:0]				vram_rdata,
	output	logic						vram_rdata_en,
	output	logic						init_busy
);
	logic	[31:0]				mem [vram_words];
	vram_state_t				state;
	logic	[vram_word_aw-1:0]	clear_addr;		// wipe position
	logic						clearing;
	logic						wr_en;
	logic	[vram_word_aw-1:0]	wr_addr;
	logic	[31:0]				wr_data;
	logic	[3:0]				wr_mask;
	logic	[31:0]				rd_word;		// array output stage
	logic						rd_pend;

	assign clearing		= (state == vs_clear);
	assign init_busy	= clearing;			// doubles as slot_wait

	// --------------------
	// wipe sequence
	// --------------------

	// one word per cycle, busy for exactly vram_words cycles
	always_ff @(posedge clk85m) begin
		if (rst) begin
			state		<= vs_clear;
			clear_addr	<= '0;
		end else if (clearing) begin
			clear_addr <= clear_addr + 1'b1;
			if (clear_addr == vram_word_aw'(vram_words - 1)) begin
				state <= vs_ready;
			end
		end
	end

	// --------------------
	// write port
	// --------------------

	// wipe owns the port while busy
	assign wr_en	= clearing | (vram_valid & vram_write);
	assign wr_addr	= clearing ? clear_addr : vram_address;
	assign wr_data	= clearing ? 32'h0000_0000 : vram_wdata;
	assign wr_mask	= clearing ? 4'hf : vram_wdata_mask;

	always_ff @(posedge clk85m) begin
		for (int i = 0; i < 4; i++) begin
			if (wr_en && wr_mask[i]) begin
				mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];	// lane i
			end
		end
	end

	// --------------------
	// read pipeline
	// --------------------

	always_ff @(posedge clk85m) begin
		if (vram_valid && !vram_write) begin
			rd_word <= mem[vram_address];		// stage 1
		end
		vram_rdata <= rd_word;					// stage 2
	end

	// strobe path, rdata_en two cycles behind the request
	always_ff @(posedge clk85m) begin
		if (rst) begin
			rd_pend			<= 1'b0;
			vram_rdata_en	<= 1'b0;
		end else begin
			rd_pend			<= vram_valid & ~vram_write;
			vram_rdata_en	<= rd_pend;
		end
	end

endmodule

/* design/vdp_cartridge.sv */
`timescale 1ns/1ps
/*
 * Cartridge top: slot front end, VDP port logic and on-chip VRAM
 */
module vdp_cartridge
	import vdp_cartridge_pkg::*;
(
	input	logic			clk85m,
	input	logic			rst,
	input	logic			slot_iorq_n,
	input	logic			slot_rd_n,
	input	logic			slot_wr_n,
	input	logic	[7:0]	slot_a,
	input	logic	[7:0]	slot_d,
	output	logic	[7:0]	slot_d_out,
	output	logic			slot_data_dir,
	output	logic			busdir,
	output	logic			slot_wait
);
	// --------------------
	// slot side bus
	// --------------------
	logic						bus_valid;
	logic						bus_port;		// address bit 0
	logic						bus_write;
	logic	[7:0]				bus_wdata;
	logic						bus_ready;
	logic	[7:0]				bus_rdata;
	logic						bus_rdata_en;

	// --------------------
	// VRAM side bus
	// --------------------
	logic						vram_valid;
	logic						vram_write;
	logic	[vram_word_aw-1:0]	vram_address;
	logic	[31:0]				vram_wdata;
	logic	[3:0]				vram_wdata_mask;
	logic	[31:0]				vram_rdata;
	logic						vram_rdata_en;
	logic						init_busy;

	assign slot_wait = init_busy;				// host stalls during wipe

	slot_bus u_slot_bus (
		.clk85m			( clk85m			),
		.rst			( rst				),
		.slot_iorq_n	( slot_iorq_n		),
		.slot_rd_n		( slot_rd_n			),
		.slot_wr_n		( slot_wr_n			),
		.slot_a			( slot_a			),
		.slot_d			( slot_d			),
		.busdir			( busdir			),
		.slot_d_out		( slot_d_out		),
		.slot_data_dir	( slot_data_dir		),
		.bus_valid		( bus_valid			),
		.bus_port		( bus_port			),
		.bus_write		( bus_write			),
		.bus_wdata		( bus_wdata			),
		.bus_ready		( bus_ready			),
		.bus_rdata_en	( bus_rdata_en		),
		.bus_rdata		( bus_rdata			)
	);

	vdp_port_ctrl u_port_ctrl (
		.clk85m				( clk85m			),
		.rst				( rst				),
		.bus_valid			( bus_valid			),
		.bus_port			( bus_port			),
		.bus_write			( bus_write			),
		.bus_wdata			( bus_wdata			),
		.bus_ready			( bus_ready			),
		.bus_rdata			( bus_rdata			),
		.bus_rdata_en		( bus_rdata_en		),
		.init_busy			( init_busy			),
		.vram_valid			( vram_valid		),
		.vram_write			( vram_write		),
		.vram_address		( vram_address		),
		.vram_wdata			( vram_wdata		),
		.vram_wdata_mask	( vram_wdata_mask	),
		.vram_rdata			( vram_rdata		),
		.vram_rdata_en		( vram_rdata_en		)
	);

	vram_ctrl u_vram (
		.clk85m				( clk85m			),
		.rst				( rst				),
		.vram_valid			( vram_valid		),
		.vram_write			( vram_write		),
		.vram_address		( vram_address		),
		.vram_wdata			( vram_wdata		),
		.vram_wdata_mask	( vram_wdata_mask	),
		.vram_rdata			( vram_rdata		),
		.vram_rdata_en		( vram_rdata_en		),
		.init_busy			( init_busy			)
	);

endmodule

/* testbench/vdp_cartridge_assertions.sv */
`timescale 1ns/1ps
/*
 * Concurrent checks on slot and VRAM strobes, bound into the cartridge top
 */
module vdp_cartridge_assertions (
	input	logic	clk85m,
	input	logic	rst,
	input	logic	slot_rd_n,
	input	logic	busdir,
	input	logic	slot_data_dir,
	input	logic	bus_valid,
	input	logic	bus_ready,
	input	logic	init_busy,
	input	logic	vram_valid,
	input	logic	vram_write,
	input	logic	vram_rdata_en
);
	logic	awaiting_ready;							// transaction out, no ready yet

	always_ff @(posedge clk85m) begin
		if (rst)
			awaiting_ready <= 1'b0;
		else if (bus_valid)
			awaiting_ready <= 1'b1;
		else if (bus_ready)
			awaiting_ready <= 1'b0;
	end

	one_outstanding: assert property (@(posedge clk85m) disable iff (rst)
		bus_valid |-> !awaiting_ready)
		else $error("bus_valid issued while a transaction awaits bus_ready");

	no_request_in_wipe: assert property (@(posedge clk85m) disable iff (rst)
		vram_valid |-> !init_busy)
		else $error("vram_valid issued while init_busy is high");

	// read answered two cycles later, no second request in between
	read_latency: assert property (@(posedge clk85m) disable iff (rst)
		$past(vram_valid & ~vram_write, 2) |-> vram_rdata_en && !$past(vram_valid))
		else $error("vram_rdata_en not two cycles after a lone read request");

	// data only driven during an in-range I/O read with rd_n low
	dir_only_on_read: assert property (@(posedge clk85m) disable iff (rst)
		slot_data_dir |-> busdir && !slot_rd_n)
		else $error("slot_data_dir high outside an in-range read");

endmodule

bind vdp_cartridge vdp_cartridge_assertions u_assertions (
	.clk85m			( clk85m		),
	.rst			( rst			),
	.slot_rd_n		( slot_rd_n		),
	.busdir			( busdir		),
	.slot_data_dir	( slot_data_dir	),
	.bus_valid		( bus_valid		),
	.bus_ready		( bus_ready		),
	.init_busy		( init_busy		),
	.vram_valid		( vram_valid	),
	.vram_write		( vram_write	),
	.vram_rdata_en	( vram_rdata_en	)
);

/* testbench/tb_vdp_cartridge.sv */
`timescale 1ns/1ps
/*
 * Testbench for the VDP cartridge: clock, reset, seeded random Z80 I/O cycles,
 * byte-level VRAM model and checks
 */
module tb_vdp_cartridge;
	localparam logic [4:0] vdp_range = 5'h13;		// 0x98..0x9F on bits 7:3
	localparam int strobe_cycles = 20;
	localparam int gap_cycles = 6;
	localparam int clear_cycles = 4096;				// one word per cycle
	localparam int io_budget = 1500;				// upper bound on I/O cycles issued
	localparam int timeout_cycles = clear_cycles +
		io_budget * (strobe_cycles + gap_cycles + 12);

	logic			clk85m;
	logic			rst;
	logic			slot_iorq_n;
	logic			slot_rd_n;
	logic			slot_wr_n;
	logic	[7:0]	slot_a;
	logic	[7:0]	slot_d;
	logic	[7:0]	slot_d_out;
	logic			slot_data_dir;
	logic			busdir;
	logic			slot_wait;

	logic	[7:0]	model_mem [16384];				// byte view of VRAM
	logic	[13:0]	model_ptr;						// wraps at 16K
	logic			model_first;					// first control byte held
	logic	[7:0]	model_low;
	logic	[7:0]	model_buf;						// read-ahead
	int				cycle_count = 0;
	int				seed_ret;

	vdp_cartridge uut (
		.clk85m			( clk85m		),
		.rst			( rst			),
		.slot_iorq_n	( slot_iorq_n	),
		.slot_rd_n		( slot_rd_n		),
		.slot_wr_n		( slot_wr_n		),
		.slot_a			( slot_a		),
		.slot_d			( slot_d		),
		.slot_d_out		( slot_d_out	),
		.slot_data_dir	( slot_data_dir	),
		.busdir			( busdir		),
		.slot_wait		( slot_wait		)
	);

	initial begin
		clk85m = 1'b0;
		forever #4 clk85m = ~clk85m;				// 125 MHz stand-in
	end

	always @(posedge clk85m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: test did not finish within %0d cycles", timeout_cycles);
			$display("Checks failed");
			$fatal(1);
		end
	end

	task automatic check(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s, expected 0x%0h, got 0x%0h",
				$time, what, expected, actual);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	// --------------------
	// VDP port model
	// --------------------

	task automatic model_prefetch;
		model_buf = model_mem[model_ptr];
		model_ptr = model_ptr + 14'd1;
	endtask

	task automatic model_ctrl_write(input logic [7:0] d);
		if (!model_first) begin
			model_low = d;
			model_first = 1'b1;
		end else begin
			model_first = 1'b0;
			if (!d[7])
				model_ptr = {d[5:0], model_low};	// register writes leave it
			if (d[7:6] == 2'b00)
				model_prefetch();					// read setup
		end
	endtask

	// --------------------
	// slot cycles
	// --------------------

	// starts and ends 1 ns after a rising edge
	task automatic io_cycle(input logic [7:0] port, input logic is_read,
			input logic [7:0] wdata, input logic [7:0] expected);
		logic	hit;
		int		dir_cycle;
		int		i;
		hit = (port[7:3] == vdp_range);
		dir_cycle = 0;
		while (slot_wait) begin						// no strobe during wipe
			@(posedge clk85m);
			#1;
		end
		slot_a = port;
		slot_d = wdata;
		slot_iorq_n = 1'b0;
		slot_rd_n = ~is_read;
		slot_wr_n = is_read;
		for (i = 1; i <= strobe_cycles; i++) begin
			@(posedge clk85m);
			#1;
			check("busdir during strobe", 32'(busdir), 32'(hit & is_read));
			if (!(hit && is_read))
				check("slot_data_dir off a read", 32'(slot_data_dir), 32'd0);
			if (slot_data_dir && dir_cycle == 0)
				dir_cycle = i;						// first cycle data is driven
		end
		if (hit && is_read) begin
			check("read latency in range", 32'(dir_cycle >= 1 && dir_cycle <= 12), 32'd1);
			check("slot_data_dir at strobe end", 32'(slot_data_dir), 32'd1);
			check("read data", 32'(slot_d_out), 32'(expected));
		end
		slot_iorq_n = 1'b1;
		slot_rd_n = 1'b1;
		slot_wr_n = 1'b1;
		repeat (gap_cycles) @(posedge clk85m);
		#1;
	endtask

	function automatic logic [7:0] vdp_port(input logic ctrl);
		return {vdp_range, 2'($urandom), ctrl};		// any mirror in the range
	endfunction

	task automatic ctrl_write(input logic [7:0] d);
		model_ctrl_write(d);
		io_cycle(vdp_port(1'b1), 1'b0, d, 8'h00);
	endtask

	task automatic ctrl_read;
		model_first = 1'b0;							// status read drops the latch
		io_cycle(vdp_port(1'b1), 1'b1, 8'h00, 8'h00);
	endtask

	task automatic data_write(input logic [7:0] d);
		model_first = 1'b0;
		model_mem[model_ptr] = d;
		model_ptr = model_ptr + 14'd1;
		io_cycle(vdp_port(1'b0), 1'b0, d, 8'h00);
	endtask

	task automatic data_read;
		logic	[7:0]	expected;
		model_first = 1'b0;
		expected = model_buf;						// old buffer goes out
		model_prefetch();
		io_cycle(vdp_port(1'b0), 1'b1, 8'h00, expected);
	endtask

	task automatic set_addr(input logic [13:0] a, input logic write_mode);
		ctrl_write(a[7:0]);
		ctrl_write({1'b0, write_mode, a[13:8]});
	endtask

	task automatic stray_access;
		logic	[7:0]	port;
		port = 8'($urandom);
		while (port[7:3] == vdp_range)
			port = 8'($urandom);
		io_cycle(port, 1'($urandom), 8'($urandom), 8'h00);
	endtask

	// --------------------
	// test sequence
	// --------------------

	initial begin : stimulus
		int				i;
		int				wait_cycles;
		int				burst_len;
		int				op;
		logic	[13:0]	addr;
		$timeformat(-9, 0, " ns", 0);
		seed_ret = $urandom(32'hdc80_a856);
		rst = 1'b1;
		slot_iorq_n = 1'b1;
		slot_rd_n = 1'b1;
		slot_wr_n = 1'b1;
		slot_a = 8'h00;
		slot_d = 8'h00;
		for (i = 0; i < 16384; i++)
			model_mem[i] = 8'h00;					// wiped contents
		model_ptr = '0;
		model_first = 1'b0;
		model_low = 8'h00;
		model_buf = 8'h00;

		repeat (10) @(posedge clk85m);
		#1;
		check("slot_wait in reset", 32'(slot_wait), 32'd1);
		check("slot_data_dir in reset", 32'(slot_data_dir), 32'd0);
		check("busdir in reset", 32'(busdir), 32'd0);
		rst = 1'b0;
		wait_cycles = 0;
		while (slot_wait) begin
			@(posedge clk85m);
			#1;
			wait_cycles++;
		end
		check("slot_wait length", 32'(wait_cycles), 32'(clear_cycles));

		repeat (8) begin							// wiped memory reads zero
			set_addr(14'($urandom), 1'b0);
			repeat (3) data_read();
		end

		for (i = 0; i < 13; i++) begin				// last burst wraps past 0x3fff
			addr = (i == 12) ? 14'h3ff0 + 14'($urandom_range(15, 0)) : 14'($urandom);
			burst_len = (i == 12) ? 32 : int'($urandom_range(24, 1));
			set_addr(addr, 1'b1);
			repeat (burst_len) data_write(8'($urandom));
			set_addr(addr, 1'b0);
			repeat (burst_len) data_read();
		end

		repeat (6) begin							// write after a read setup
			addr = 14'($urandom);
			set_addr(addr, 1'b0);
			repeat (3) data_read();
			repeat (2) data_write(8'($urandom));
			set_addr(addr, 1'b0);
			repeat (8) data_read();
		end

		repeat (6) begin							// status read mid setup
			addr = 14'($urandom);
			ctrl_write(8'($urandom));
			ctrl_read();
			set_addr(addr, 1'b1);
			data_write(8'($urandom));
			set_addr(addr, 1'b0);
			data_read();
		end

		repeat (40) stray_access();					// pointer must not move
		repeat (2) data_read();

		repeat (500) begin
			op = int'($urandom_range(9, 0));
			if (op < 3)
				data_write(8'($urandom));
			else if (op < 6)
				data_read();
			else if (op < 8)
				ctrl_write(8'($urandom));
			else if (op == 8)
				ctrl_read();
			else
				stray_access();
		end

		$display("All checks passed");
		$finish;
	end

endmodule

/* vdp_cartridge.f */
design/vdp_cartridge_pkg.sv
design/slot_bus.sv
design/vdp_port_ctrl.sv
design/vram_ctrl.sv
design/vdp_cartridge.sv
testbench/vdp_cartridge_assertions.sv
testbench/tb_vdp_cartridge.sv

/* run_sim.sh */
#!/bin/sh
# build and run the VDP cartridge testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--top-module tb_vdp_cartridge \
	-f vdp_cartridge.f \
	-o sim_vdp_cartridge
output=$(./obj_dir/sim_vdp_cartridge 2>&1) || true
echo "$output"
if echo "$output" | grep -qx "All checks passed"; then
	exit 0
fi
echo "simulation failed"
exit 1
